// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
soc_pkg.sv
mem_bus_if.sv
bus_decoder.sv
soc_ram.sv
gpio_regs.sv
uart_tx.sv
soc_top.sv
tb_soc.sv

// ==== bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  logic                           clk_rv,
    input  logic                           core_rst_n,
    input  logic                           mem_valid,
    input  logic [soc_pkg::addr_width-1:0] mem_addr,
    input  logic [soc_pkg::addr_width-1:0] mem_la_addr,
    input  logic [soc_pkg::data_width-1:0] mem_wdata,
    input  logic [soc_pkg::strb_width-1:0] mem_wstrb,
    output logic                           mem_ready,
    output logic [soc_pkg::data_width-1:0] mem_rdata,
    output logic                           bus_irq,
    mem_bus_if.host                        ram_bus,
    mem_bus_if.host                        gpio_bus,
    mem_bus_if.host                        uart_bus
);

    soc_pkg::bus_region_e region_q;
    logic                 valid_q;
    logic                 none_ready;

    // ----------------------------------------------------------
    // Look-ahead decode
    // ----------------------------------------------------------
    // Region is taken from the look-ahead address while the bus is
    // idle and held for the whole access
    always_ff @(posedge clk_rv) begin
        if (!core_rst_n) begin
            region_q <= soc_pkg::region_none;
        end else if (!mem_valid) begin
            region_q <= soc_pkg::addr_region(mem_la_addr);
        end
    end

    assign ram_bus.sel    = mem_valid && (region_q == soc_pkg::region_ram);
    assign ram_bus.addr   = mem_addr;
    assign ram_bus.wdata  = mem_wdata;
    assign ram_bus.wstrb  = mem_wstrb;

    assign gpio_bus.sel   = mem_valid && (region_q == soc_pkg::region_gpio);
    assign gpio_bus.addr  = mem_addr;
    assign gpio_bus.wdata = mem_wdata;
    assign gpio_bus.wstrb = mem_wstrb;

    assign uart_bus.sel   = mem_valid && (region_q == soc_pkg::region_uart);
    assign uart_bus.addr  = mem_addr;
    assign uart_bus.wdata = mem_wdata;
    assign uart_bus.wstrb = mem_wstrb;

    // ----------------------------------------------------------
    // Response merge and bus error
    // ----------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!core_rst_n) begin
            valid_q    <= 1'b0;
            none_ready <= 1'b0;
            bus_irq    <= 1'b0;
        end else begin
            valid_q    <= mem_valid;
            // Unmapped accesses still complete one cycle later
            none_ready <= mem_valid && (region_q == soc_pkg::region_none) && !none_ready;
            // Sticky until the next reset
            if (mem_valid && !valid_q && (region_q == soc_pkg::region_none)) begin
                bus_irq <= 1'b1;
            end
        end
    end

    assign mem_ready = ram_bus.ready | gpio_bus.ready | uart_bus.ready | none_ready;

    always_comb begin
        case (region_q)
            soc_pkg::region_ram:  mem_rdata = ram_bus.rdata;
            soc_pkg::region_gpio: mem_rdata = gpio_bus.rdata;
            soc_pkg::region_uart: mem_rdata = uart_bus.rdata;
            default:              mem_rdata = soc_pkg::unmapped_rdata;
        endcase
    end

endmodule

// ==== gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs (
    input  logic                                clk_rv,
    input  logic                                core_rst_n,
    mem_bus_if.target                           bus,
    input  logic [soc_pkg::delay_sel_width-1:0] delay_sel_det,
    input  logic                                spi_miso,
    output logic                                led_red_n,
    output logic                                led_green_n,
    output logic                                led_blue_n,
    output logic                                spi_cs_n,
    output logic                                spi_sck,
    output logic                                spi_mosi,
    output logic                                usb_rst_n,
    output logic [soc_pkg::delay_sel_width-1:0] delay_sel
);

    logic                           led_red;
    logic                           led_green;
    logic                           led_blue;
    logic                           access;
    logic                           is_write;
    soc_pkg::gpio_reg_e             reg_idx;
    logic [soc_pkg::data_width-1:0] read_mux;

    assign access   = bus.sel && !bus.ready;
    assign is_write = |bus.wstrb;
    assign reg_idx  = soc_pkg::gpio_reg_e'(bus.addr[5:2]);

    // ----------------------------------------------------------
    // Register writes
    // ----------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!core_rst_n) begin
            bus.ready <= 1'b0;
            delay_sel <= delay_sel_det;
            led_red   <= 1'b0;
            led_green <= 1'b0;
            led_blue  <= 1'b0;
            spi_cs_n  <= 1'b1;
            spi_sck   <= 1'b0;
            spi_mosi  <= 1'b0;
            usb_rst_n <= 1'b0;
        end else begin
            bus.ready <= access;
            if (access && is_write) begin
                case (reg_idx)
                    soc_pkg::reg_delay_sel: delay_sel <= bus.wdata[soc_pkg::delay_sel_width-1:0];
                    soc_pkg::reg_leds: begin
                        led_red   <= bus.wdata[2];
                        led_green <= bus.wdata[1];
                        led_blue  <= bus.wdata[0];
                    end
                    soc_pkg::reg_spi_cs:   spi_cs_n  <= bus.wdata[0];
                    soc_pkg::reg_spi_clk:  spi_sck   <= bus.wdata[0];
                    soc_pkg::reg_spi_mosi: spi_mosi  <= bus.wdata[0];
                    soc_pkg::reg_usb_rst:  usb_rst_n <= bus.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // Read-back
    // ----------------------------------------------------------
    always_comb begin
        read_mux = '0;
        case (reg_idx)
            soc_pkg::reg_delay_sel: read_mux[soc_pkg::delay_sel_width-1:0] = delay_sel;
            soc_pkg::reg_leds:      read_mux[2:0] = {led_red, led_green, led_blue};
            soc_pkg::reg_spi_miso:  read_mux[0] = spi_miso;
            default: ;
        endcase
    end

    always_ff @(posedge clk_rv) begin
        if (access) begin
            bus.rdata <= read_mux;
        end
    end

    // Board LEDs are lit by a low pin
    assign led_red_n   = ~led_red;
    assign led_green_n = ~led_green;
    assign led_blue_n  = ~led_blue;

endmodule

// ==== mem_bus_if.sv ====
`timescale 1ns/1ps

// One decoder-to-target link of the memory bus
interface mem_bus_if;

    logic                              sel;
    logic [soc_pkg::addr_width-1:0]    addr;
    logic [soc_pkg::data_width-1:0]    wdata;
    logic [soc_pkg::strb_width-1:0]    wstrb;
    logic [soc_pkg::data_width-1:0]    rdata;
    logic                              ready;

    modport host (
        output sel,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  ready
    );

    modport target (
        input  sel,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output ready
    );

endinterface

// ==== soc_input.txt ====
# kind addr wdata strb expect rnd, all hex but rnd; read expect is mem_rdata
# serial expect 1 = held, miso drives wdata bit 0, pins = {delay_sel, usb, mosi, sck, cs, b, g, r}
irq    00000000 00000000 0 00000000 0
write  0E000010 11223344 f 00000000 0
write  0E000010 AABBCCDD 5 00000000 0
read   0E000010 00000000 0 11BB33DD 0
write  0E000020 FFFFFFFF f 00000000 0
write  0E000020 00000000 6 00000000 0
read   0E000020 00000000 0 FF0000FF 0
write  0E000FFC 00000000 f 00000000 1
read   0E000FFC 00000000 0 00000000 1
write  03000004 00000005 1 00000000 0
write  03000000 00000009 1 00000000 0
write  0300000C 00000000 1 00000000 0
write  03000010 00000001 1 00000000 0
write  03000014 00000001 1 00000000 0
write  0300001C 00000001 1 00000000 0
pins   00000000 00000000 0 000004F2 0
read   03000004 00000000 0 00000005 0
read   03000000 00000000 0 00000009 0
read   03000010 00000000 0 00000000 0
read   03000018 00000000 0 00000000 0
miso   00000000 00000001 0 00000000 0
read   03000018 00000000 0 00000001 0
serial 03000100 000000A5 1 00000000 0
serial 03000100 0000003C 1 00000001 0
irq    00000000 00000000 0 00000000 0
read   05000000 00000000 0 FFFFFFFF 0
irq    00000000 00000000 0 00000001 0
read   0E000010 00000000 0 11BB33DD 0
irq    00000000 00000000 0 00000001 0

// ==== soc_pkg.sv ====
package soc_pkg;

    // ----------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = 4;

    // ----------------------------------------------------------
    // Address map
    // ----------------------------------------------------------
    localparam logic [addr_width-1:0] gpio_base = 32'h0300_0000;
    localparam int gpio_size = 256;
    localparam logic [addr_width-1:0] uart_addr = 32'h0300_0100;
    localparam logic [addr_width-1:0] ram_base = 32'h0E00_0000;
    localparam int ram_size = 4096;
    localparam int ram_words = ram_size / strb_width;
    localparam int ram_index_width = $clog2(ram_words);

    // Returned for unmapped regions and the write-only serial port
    localparam logic [data_width-1:0] unmapped_rdata = '1;

    localparam int delay_sel_width = 5;

    // Timing
    localparam int reset_hold_cycles = 16;
    localparam int reset_cnt_width = $clog2(reset_hold_cycles);
    localparam logic [reset_cnt_width-1:0] reset_cnt_last =
        reset_cnt_width'(reset_hold_cycles - 1);
    localparam int uart_clks_per_bit = 8;
    localparam int uart_cnt_width = $clog2(uart_clks_per_bit);
    localparam logic [uart_cnt_width-1:0] uart_cnt_last =
        uart_cnt_width'(uart_clks_per_bit - 1);

    typedef enum logic [1:0] {
        region_none,
        region_gpio,
        region_uart,
        region_ram
    } bus_region_e;

    // Word index within the GPIO block from address bits 5:2
    typedef enum logic [3:0] {
        reg_delay_sel = 4'd0,
        reg_leds      = 4'd1,
        reg_spi_cs    = 4'd3,
        reg_spi_clk   = 4'd4,
        reg_spi_mosi  = 4'd5,
        reg_spi_miso  = 4'd6,
        reg_usb_rst   = 4'd7
    } gpio_reg_e;

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uart_state_e;

    function automatic bus_region_e addr_region(input logic [addr_width-1:0] addr);
        bus_region_e region;
        region = region_none;
        if (addr == uart_addr) begin
            region = region_uart;
        end else if (addr >= gpio_base && addr < gpio_base + gpio_size) begin
            region = region_gpio;
        end else if (addr >= ram_base && addr < ram_base + ram_size) begin
            region = region_ram;
        end
        return region;
    endfunction

endpackage

// ==== soc_ram.sv ====
`timescale 1ns/1ps

module soc_ram (
    input  logic       clk_rv,
    input  logic       core_rst_n,
    mem_bus_if.target  bus
);

    logic [soc_pkg::data_width-1:0]      words [soc_pkg::ram_words];
    logic [soc_pkg::ram_index_width-1:0] word_idx;
    logic                                access;

    assign word_idx = bus.addr[soc_pkg::ram_index_width+1:2];
    // First cycle of the access only
    assign access   = bus.sel && !bus.ready;

    always_ff @(posedge clk_rv) begin
        if (!core_rst_n) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= access;
        end
    end

    // Byte-lane writes with the read data landing in the ready cycle
    always_ff @(posedge clk_rv) begin
        if (access) begin
            for (int i = 0; i < soc_pkg::strb_width; i++) begin
                if (bus.wstrb[i]) begin
                    words[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
            bus.rdata <= words[word_idx];
        end
    end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
    input  logic                                clk_rv,
    input  logic                                rst_rv,
    input  logic                                mem_valid,
    input  logic [soc_pkg::addr_width-1:0]      mem_addr,
    input  logic [soc_pkg::addr_width-1:0]      mem_la_addr,
    input  logic [soc_pkg::data_width-1:0]      mem_wdata,
    input  logic [soc_pkg::strb_width-1:0]      mem_wstrb,
    input  logic [soc_pkg::delay_sel_width-1:0] delay_sel_det,
    input  logic                                spi_miso,
    output logic                                mem_ready,
    output logic [soc_pkg::data_width-1:0]      mem_rdata,
    output logic                                bus_irq,
    output logic                                cpu_rst_n,
    output logic                                led_red_n,
    output logic                                led_green_n,
    output logic                                led_blue_n,
    output logic                                spi_cs_n,
    output logic                                spi_sck,
    output logic                                spi_mosi,
    output logic                                usb_rst_n,
    output logic [soc_pkg::delay_sel_width-1:0] delay_sel,
    output logic                                uart_txd
);

    logic                                rst_sync;
    logic [soc_pkg::reset_cnt_width-1:0] rst_cnt;

    // ----------------------------------------------------------
    // Core reset stretcher
    // ----------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        rst_sync <= rst_rv;
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_sync) begin
            rst_cnt   <= '0;
            cpu_rst_n <= 1'b0;
        end else if (rst_cnt == soc_pkg::reset_cnt_last) begin
            cpu_rst_n <= 1'b1;
        end else begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Bus fabric and targets
    // ----------------------------------------------------------
    mem_bus_if ram_bus ();
    mem_bus_if gpio_bus ();
    mem_bus_if uart_bus ();

    bus_decoder u_bus_decoder (
        .clk_rv      (clk_rv),
        .core_rst_n  (cpu_rst_n),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_la_addr (mem_la_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .bus_irq     (bus_irq),
        .ram_bus     (ram_bus.host),
        .gpio_bus    (gpio_bus.host),
        .uart_bus    (uart_bus.host)
    );

    soc_ram u_soc_ram (
        .clk_rv     (clk_rv),
        .core_rst_n (cpu_rst_n),
        .bus        (ram_bus.target)
    );

    gpio_regs u_gpio_regs (
        .clk_rv        (clk_rv),
        .core_rst_n    (cpu_rst_n),
        .bus           (gpio_bus.target),
        .delay_sel_det (delay_sel_det),
        .spi_miso      (spi_miso),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .led_blue_n    (led_blue_n),
        .spi_cs_n      (spi_cs_n),
        .spi_sck       (spi_sck),
        .spi_mosi      (spi_mosi),
        .usb_rst_n     (usb_rst_n),
        .delay_sel     (delay_sel)
    );

    uart_tx u_uart_tx (
        .clk_rv     (clk_rv),
        .core_rst_n (cpu_rst_n),
        .bus        (uart_bus.target),
        .uart_txd   (uart_txd)
    );

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc;

    localparam int reset_cycles    = 10;
    localparam int hold_cycles     = 16;
    localparam int cycles_per_line = 200;
    localparam int uart_bit        = 8;
    localparam logic [31:0] gpio_base_addr = 32'h0300_0000;

    logic        clk_rv = 1'b0;
    logic        rst_rv;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_la_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic [4:0]  delay_sel_det;
    logic        spi_miso;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        bus_irq;
    logic        cpu_rst_n;
    logic        led_red_n;
    logic        led_green_n;
    logic        led_blue_n;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        usb_rst_n;
    logic [4:0]  delay_sel;
    logic        uart_txd;

    // One entry per data line
    string       kinds [$];
    logic [31:0] addrs [$];
    logic [31:0] wdatas [$];
    logic [31:0] strbs [$];
    logic [31:0] expects [$];
    int          rnds [$];

    logic [7:0]  tx_bytes [$];
    logic [31:0] last_random;
    logic        loaded = 1'b0;
    int          seed = 57;
    int          value_errors = 0;
    int          other_errors = 0;
    int          frames_sent = 0;
    int          frames_done = 0;

    soc_top u_soc_top (.*);

    always #2 clk_rv = ~clk_rv;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] e;
        int          r;
        fd = $fopen("soc_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open soc_input.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %d", kind, a, w, s, e, r);
            if (n != 6) begin
                $display("Malformed line in soc_input.txt: %s", line);
                other_errors++;
            end else begin
                kinds.push_back(kind);
                addrs.push_back(a);
                wdatas.push_back(w);
                strbs.push_back(s);
                expects.push_back(e);
                rnds.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Bit order {delay_sel, usb_rst_n, spi_mosi, spi_sck, spi_cs_n, blue, green, red}
    task automatic check_pins(input logic [31:0] e);
        check_value("led_red_n", 32'(led_red_n), 32'(e[0]));
        check_value("led_green_n", 32'(led_green_n), 32'(e[1]));
        check_value("led_blue_n", 32'(led_blue_n), 32'(e[2]));
        check_value("spi_cs_n", 32'(spi_cs_n), 32'(e[3]));
        check_value("spi_sck", 32'(spi_sck), 32'(e[4]));
        check_value("spi_mosi", 32'(spi_mosi), 32'(e[5]));
        check_value("usb_rst_n", 32'(usb_rst_n), 32'(e[6]));
        check_value("delay_sel", 32'(delay_sel), 32'(e[11:7]));
    endtask

    // Look-ahead address one cycle before valid and hold until ready
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output int latency);
        @(posedge clk_rv);
        mem_la_addr <= addr;
        @(posedge clk_rv);
        mem_valid <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= strb;
        latency = 0;
        @(negedge clk_rv);
        while (!mem_ready) begin
            latency++;
            @(negedge clk_rv);
        end
        rdata = mem_rdata;
        @(posedge clk_rv);
        mem_valid <= 1'b0;
        mem_wstrb <= '0;
    endtask

    task automatic check_latency(input int latency);
        assert (latency == 1) else begin
            other_errors++;
            $display("mem_ready came %0d cycles after mem_valid instead of one", latency);
        end
    endtask

    // Red alone on tells the LED bit order apart
    task automatic led_order_test();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          latency;
        addr = gpio_base_addr + 32'(soc_pkg::reg_leds) * 4;
        bus_access(addr, 32'h0000_0004, 4'h1, rdata, latency);
        check_latency(latency);
        @(negedge clk_rv);
        check_value("led_red_n", 32'(led_red_n), 32'h0);
        check_value("led_green_n", 32'(led_green_n), 32'h1);
        check_value("led_blue_n", 32'(led_blue_n), 32'h1);
        bus_access(addr, 32'h0, 4'h0, rdata, latency);
        check_latency(latency);
        check_value("mem_rdata", rdata, 32'h0000_0004);
    endtask

    task automatic run_line(input int i);
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [31:0] exp;
        int          latency;
        wdata = wdatas[i];
        exp   = expects[i];
        if (rnds[i] != 0 && kinds[i] == "write") begin
            last_random = $random(seed);
            wdata = last_random;
        end
        if (rnds[i] != 0) begin
            exp = last_random;
        end
        if (kinds[i] == "write" || kinds[i] == "read") begin
            bus_access(addrs[i], wdata, strbs[i][3:0], rdata, latency);
            check_latency(latency);
            if (kinds[i] == "read") begin
                check_value("mem_rdata", rdata, exp);
            end
        end else if (kinds[i] == "serial") begin
            bus_access(addrs[i], wdata, strbs[i][3:0], rdata, latency);
            if (exp[0]) begin
                assert (latency > 1) else begin
                    other_errors++;
                    $display("Serial write was not held while a frame was being sent");
                end
            end else begin
                check_latency(latency);
            end
            assert (frames_done == frames_sent) else begin
                other_errors++;
                $display("Serial write was accepted before the previous frame ended");
            end
            tx_bytes.push_back(wdata[7:0]);
            frames_sent++;
        end else if (kinds[i] == "pins") begin
            @(negedge clk_rv);
            check_pins(exp);
        end else if (kinds[i] == "irq") begin
            @(negedge clk_rv);
            check_value("bus_irq", 32'(bus_irq), exp);
        end else if (kinds[i] == "miso") begin
            @(posedge clk_rv);
            spi_miso <= wdata[0];
        end else begin
            other_errors++;
            $display("Unknown line kind %s in soc_input.txt", kinds[i]);
        end
    endtask

    // ----------------------------------------------------------
    // Serial receiver sampling each bit in its middle
    // ----------------------------------------------------------
    always begin : serial_monitor
        logic [7:0] got;
        logic [7:0] exp;
        @(negedge clk_rv);
        if (cpu_rst_n === 1'b1 && uart_txd === 1'b0) begin
            repeat (uart_bit / 2) @(negedge clk_rv);
            check_value("uart_txd start bit", 32'(uart_txd), 32'h0);
            for (int i = 0; i < 8; i++) begin
                repeat (uart_bit) @(negedge clk_rv);
                got[i] = uart_txd;
            end
            repeat (uart_bit) @(negedge clk_rv);
            check_value("uart_txd stop bit", 32'(uart_txd), 32'h1);
            assert (tx_bytes.size() != 0) else begin
                other_errors++;
                $display("A serial frame appeared without a serial write");
            end
            if (tx_bytes.size() != 0) begin
                exp = tx_bytes.pop_front();
                check_value("uart_txd byte", 32'(got), 32'(exp));
            end
            repeat (uart_bit / 2) @(negedge clk_rv);
            frames_done++;
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main_sequence
        int cycles;
        rst_rv        = 1'b0;
        mem_valid     = 1'b0;
        mem_addr      = '0;
        mem_la_addr   = '0;
        mem_wdata     = '0;
        mem_wstrb     = '0;
        delay_sel_det = 5'h13;
        spi_miso      = 1'b0;
        read_stimulus();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk_rv);
        rst_rv <= 1'b1;
        // Edges counted from the first one that sees rst_rv high
        cycles = -1;
        do begin
            @(posedge clk_rv);
            cycles++;
            @(negedge clk_rv);
        end while (cpu_rst_n !== 1'b1);
        assert (cycles == hold_cycles) else begin
            other_errors++;
            $display("cpu_rst_n rose %0d cycles after rst_rv instead of %0d",
                     cycles, hold_cycles);
        end
        check_pins({20'd0, delay_sel_det, 7'b0001111});
        check_value("mem_ready", 32'(mem_ready), 32'h0);
        check_value("uart_txd", 32'(uart_txd), 32'h1);
        for (int i = 0; i < kinds.size(); i++) begin
            run_line(i);
        end
        led_order_test();
        while (frames_done < frames_sent) begin
            @(negedge clk_rv);
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && kinds.size() > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = (kinds.size() + 1) * cycles_per_line + reset_cycles + hold_cycles + 4;
        repeat (limit) @(posedge clk_rv);
        $display("Timeout after %0d cycles, the run did not complete", limit);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk_rv,
    input  logic       core_rst_n,
    mem_bus_if.target  bus,
    output logic       uart_txd
);

    soc_pkg::uart_state_e                state;
    logic [soc_pkg::uart_cnt_width-1:0]  baud_cnt;
    logic [2:0]                          bit_idx;
    logic [7:0]                          shift;
    logic                                bit_done;
    logic                                accept;

    assign bit_done  = (baud_cnt == soc_pkg::uart_cnt_last);
    // Only taken while idle, so a write during a frame waits here
    assign accept    = (state == soc_pkg::idle) && bus.sel && !bus.ready;
    assign bus.rdata = soc_pkg::unmapped_rdata;

    always_ff @(posedge clk_rv) begin
        if (!core_rst_n) begin
            state     <= soc_pkg::idle;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= accept;
            if (state == soc_pkg::idle || bit_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (state)
                soc_pkg::idle: begin
                    if (accept && |bus.wstrb) begin
                        state <= soc_pkg::start;
                    end
                end
                soc_pkg::start: begin
                    if (bit_done) begin
                        state   <= soc_pkg::data;
                        bit_idx <= '0;
                    end
                end
                soc_pkg::data: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= soc_pkg::stop;
                        end
                    end
                end
                soc_pkg::stop: begin
                    if (bit_done) begin
                        state <= soc_pkg::idle;
                    end
                end
                default: state <= soc_pkg::idle;
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk_rv) begin
        if (accept) begin
            shift <= bus.wdata[7:0];
        end else if (state == soc_pkg::data && bit_done) begin
            shift <= shift >> 1;
        end
    end

    always_comb begin
        case (state)
            soc_pkg::start: uart_txd = 1'b0;
            soc_pkg::data:  uart_txd = shift[0];
            default:        uart_txd = 1'b1;
        endcase
    end

endmodule
